// ==== cache_pkg.sv ====
package cache_pkg;

    // cache geometry.
    localparam int CACHE_WAYS = 2;
    localparam int CACHE_SETS = 16;
    localparam int LINE_WORDS = 8;

    // derived field widths of the host byte address.
    localparam int HOST_AW   = 17;
    localparam int SET_W     = $clog2(CACHE_SETS);
    localparam int WSEL_W    = $clog2(LINE_WORDS);
    localparam int TAG_W     = HOST_AW - SET_W - WSEL_W - 1;
    localparam int RAM_WORDS = CACHE_SETS * LINE_WORDS;

    typedef logic [HOST_AW-1:0]              host_addr_t;
    typedef logic [TAG_W-1:0]                tag_t;
    typedef logic [SET_W-1:0]                set_t;
    typedef logic [WSEL_W-1:0]               word_sel_t;
    typedef logic [SET_W+WSEL_W-1:0]         ram_addr_t;
    typedef logic [TAG_W+SET_W+WSEL_W-1:0]   sdram_addr_t;
    typedef logic [7:0]                      byte_t;
    typedef logic [15:0]                     word_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT_READ,
        HIT_WRITE,
        EVICT,
        FILL_REQ,
        FILL,
        FINISH
    } ctrl_state_t;

    function automatic tag_t addr_tag(host_addr_t a);
        return a[HOST_AW-1 -: TAG_W];
    endfunction

    function automatic set_t addr_set(host_addr_t a);
        return a[WSEL_W+1 +: SET_W];
    endfunction

    function automatic word_sel_t addr_word(host_addr_t a);
        return a[1 +: WSEL_W];
    endfunction

    // byte 0 of a word sits in the upper half.
    function automatic byte_t word_byte(word_t w, logic lsb);
        return lsb ? w[7:0] : w[15:8];
    endfunction

endpackage

// ==== cache_spram.sv ====
module cache_spram import cache_pkg::*; (
    input  logic       sys_clk,
    input  ram_addr_t  addr,
    input  word_t      wdata,
    input  logic [1:0] we,
    output word_t      q
);

    word_t mem [RAM_WORDS];

    // registered read that returns the old word when written in the same cycle.
    always_ff @(posedge sys_clk) begin
        if (we[1]) begin
            mem[addr][15:8] <= wdata[15:8];
        end
        if (we[0]) begin
            mem[addr][7:0] <= wdata[7:0];
        end
        q <= mem[addr];
    end

endmodule

// ==== cache_tags.sv ====
module cache_tags import cache_pkg::*; (
    input  logic sys_clk,
    input  logic reset_n,
    input  set_t set_sel,
    input  tag_t lookup_tag,
    input  logic way_sel,
    input  logic set_valid,
    input  logic set_dirty,
    input  logic touch,
    output logic hit_w0,
    output logic hit_w1,
    output logic victim_way,
    output logic victim_dirty,
    output tag_t victim_tag
);

    tag_t tag_mem [CACHE_WAYS][CACHE_SETS];

    logic [CACHE_WAYS-1:0][CACHE_SETS-1:0] valid_q;
    logic [CACHE_WAYS-1:0][CACHE_SETS-1:0] dirty_q;
    // each set keeps one bit that names its least recently used way.
    logic [CACHE_SETS-1:0]                 lru_q;

    logic [CACHE_WAYS-1:0] way_valid;
    logic [CACHE_WAYS-1:0] way_dirty;
    logic [CACHE_WAYS-1:0] way_hit;

    always_comb begin
        for (int w = 0; w < CACHE_WAYS; w++) begin
            way_valid[w] = valid_q[w][set_sel];
            way_dirty[w] = dirty_q[w][set_sel];
            way_hit[w]   = way_valid[w] && (tag_mem[w][set_sel] == lookup_tag);
        end
    end

    assign hit_w0 = way_hit[0];
    assign hit_w1 = way_hit[1];

    // empty way first, then the clean one of a mixed pair, then LRU.
    always_comb begin
        if (!way_valid[0]) begin
            victim_way = 1'b0;
        end else if (!way_valid[1]) begin
            victim_way = 1'b1;
        end else if (way_dirty[0] != way_dirty[1]) begin
            victim_way = way_dirty[0];
        end else begin
            victim_way = lru_q[set_sel];
        end
    end

    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];
    assign victim_tag   = tag_mem[victim_way][set_sel];

    always_ff @(posedge sys_clk) begin
        if (set_valid) begin
            tag_mem[way_sel][set_sel] <= lookup_tag;
        end
    end

    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (set_valid) begin
                valid_q[way_sel][set_sel] <= 1'b1;
                dirty_q[way_sel][set_sel] <= 1'b0;
            end
            // a write miss marks the fresh line dirty in the same cycle.
            if (set_dirty) begin
                dirty_q[way_sel][set_sel] <= 1'b1;
            end
            if (touch) begin
                lru_q[set_sel] <= ~way_sel;
            end
        end
    end

    // the controller only fills on a miss, so a tag never lives in both ways.
    a_no_dup_tag: assert property (@(posedge sys_clk) disable iff (!reset_n)
        !(way_valid[0] && way_valid[1] && (tag_mem[0][set_sel] == tag_mem[1][set_sel])));

endmodule

// ==== cache_ctrl.sv ====
module cache_ctrl import cache_pkg::*; #(
    parameter bit READ_FORWARD = 1'b1
) (
    input  logic        sys_clk,
    input  logic        reset_n,
    // host side.
    input  host_addr_t  address,
    input  byte_t       data_write,
    input  logic        read_req,
    input  logic        write_req,
    output logic        read_ack,
    output byte_t       data_read,
    output logic        write_ack,
    // SDRAM side.
    output sdram_addr_t sdram_address,
    output word_t       sdram_data_write,
    input  word_t       sdram_data_read,
    output logic        sdram_read_req,
    output logic        sdram_write_req,
    input  logic        sdram_read_ack,
    input  logic        sdram_write_ack,
    // tag store.
    output set_t        set_sel,
    output tag_t        lookup_tag,
    output logic        way_sel,
    output logic        set_valid,
    output logic        set_dirty,
    output logic        touch,
    input  logic        hit_w0,
    input  logic        hit_w1,
    input  logic        victim_way,
    input  logic        victim_dirty,
    input  tag_t        victim_tag,
    // data RAMs.
    output ram_addr_t   ram_addr,
    output word_t       ram_wdata,
    output logic [1:0]  ram_we_w0,
    output logic [1:0]  ram_we_w1,
    input  word_t       q_w0,
    input  word_t       q_w1
);

    localparam word_sel_t LAST_WORD = word_sel_t'(LINE_WORDS - 1);

    ctrl_state_t state;

    host_addr_t req_addr;
    byte_t      req_data;
    logic       req_write;
    logic       pend_valid;
    host_addr_t pend_addr;
    byte_t      pend_data;
    logic       pend_write;
    // hit way after a hit, victim way after a miss.
    logic       way_q;
    // word counter for both the write-back and the fill.
    word_sel_t  cnt;

    logic       new_req;
    logic       hit;
    logic       word_match;
    logic       fill_last;
    logic       wb_last;
    logic       take_input;
    logic       take_pend;
    logic       hold_pend;
    word_t      way_data;
    word_t      fill_word;
    logic [1:0] ram_we;

    assign new_req    = read_req | write_req;
    assign hit        = hit_w0 | hit_w1;
    assign word_match = (cnt == addr_word(req_addr));
    assign fill_last  = (state == FILL) && sdram_read_ack && (cnt == LAST_WORD);
    assign wb_last    = (state == EVICT) && sdram_write_ack && (cnt == LAST_WORD);

    // a request comes straight from the bus or from the pending slot after a fill.
    assign take_input = ((state == IDLE || state == FINISH) && new_req) ||
                        (fill_last && !pend_valid && new_req);
    assign take_pend  = fill_last && pend_valid;
    assign hold_pend  = (state == FILL) && !fill_last && new_req;

    assign way_data         = way_q ? q_w1 : q_w0;
    assign sdram_data_write = way_data;

    // merge the host byte into the incoming word on a write miss.
    always_comb begin
        fill_word = sdram_data_read;
        if (req_write && word_match) begin
            if (req_addr[0]) begin
                fill_word[7:0] = req_data;
            end else begin
                fill_word[15:8] = req_data;
            end
        end
    end

    always_comb begin
        ram_addr  = {addr_set(req_addr), addr_word(req_addr)};
        ram_wdata = {req_data, req_data};
        ram_we    = 2'b00;
        case (state)
            HIT_WRITE: begin
                ram_we = req_addr[0] ? 2'b01 : 2'b10;
            end
            EVICT: begin
                // read one word ahead so the next word is on the bus after each ack.
                ram_addr = {addr_set(req_addr),
                            sdram_write_ack ? word_sel_t'(cnt + 1'b1) : cnt};
            end
            FILL: begin
                ram_addr  = {addr_set(req_addr), cnt};
                ram_wdata = fill_word;
                if (sdram_read_ack) begin
                    ram_we = 2'b11;
                end
            end
            default: begin
            end
        endcase
    end

    assign ram_we_w0 = way_q ? 2'b00 : ram_we;
    assign ram_we_w1 = way_q ? ram_we : 2'b00;

    assign set_sel    = addr_set(req_addr);
    assign lookup_tag = addr_tag(req_addr);
    assign way_sel    = (state == LOOKUP) ? hit_w1 : way_q;
    assign touch      = ((state == LOOKUP) && hit) || fill_last;
    assign set_valid  = fill_last;
    assign set_dirty  = (state == HIT_WRITE) || (fill_last && req_write);

    always_ff @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= IDLE;
            read_ack        <= 1'b0;
            write_ack       <= 1'b0;
            sdram_read_req  <= 1'b0;
            sdram_write_req <= 1'b0;
            pend_valid      <= 1'b0;
            way_q           <= 1'b0;
            cnt             <= '0;
        end else begin
            read_ack  <= 1'b0;
            write_ack <= 1'b0;
            case (state)
                IDLE, FINISH: begin
                    state <= new_req ? LOOKUP : IDLE;
                end
                LOOKUP: begin
                    cnt <= '0;
                    if (hit) begin
                        way_q <= hit_w1;
                        state <= req_write ? HIT_WRITE : HIT_READ;
                    end else begin
                        way_q <= victim_way;
                        state <= victim_dirty ? EVICT : FILL_REQ;
                    end
                end
                HIT_READ: begin
                    read_ack <= 1'b1;
                    state    <= FINISH;
                end
                HIT_WRITE: begin
                    write_ack <= 1'b1;
                    state     <= FINISH;
                end
                EVICT: begin
                    if (sdram_write_ack) begin
                        cnt <= word_sel_t'(cnt + 1'b1);
                    end
                    if (wb_last) begin
                        sdram_write_req <= 1'b0;
                        state           <= FILL_REQ;
                    end else begin
                        sdram_write_req <= 1'b1;
                    end
                end
                FILL_REQ: begin
                    cnt            <= '0;
                    sdram_read_req <= 1'b1;
                    state          <= FILL;
                end
                FILL: begin
                    if (sdram_read_ack) begin
                        cnt <= word_sel_t'(cnt + 1'b1);
                        if (!req_write && (READ_FORWARD ? word_match : fill_last)) begin
                            read_ack <= 1'b1;
                        end
                    end
                    if (fill_last) begin
                        sdram_read_req <= 1'b0;
                        write_ack      <= req_write;
                        pend_valid     <= 1'b0;
                        state          <= (take_pend || take_input) ? LOOKUP : FINISH;
                    end else if (hold_pend) begin
                        pend_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take_pend) begin
            req_addr  <= pend_addr;
            req_data  <= pend_data;
            req_write <= pend_write;
        end else if (take_input) begin
            req_addr  <= address;
            req_data  <= data_write;
            req_write <= write_req;
        end
        if (hold_pend) begin
            pend_addr  <= address;
            pend_data  <= data_write;
            pend_write <= write_req;
        end
        // write-back base first, then the fill base.
        if (state == LOOKUP) begin
            sdram_address <= {victim_tag, addr_set(req_addr), word_sel_t'(0)};
        end else if (state == FILL_REQ) begin
            sdram_address <= {addr_tag(req_addr), addr_set(req_addr), word_sel_t'(0)};
        end
        if (state == HIT_READ) begin
            data_read <= word_byte(way_data, req_addr[0]);
        end else if ((state == FILL) && sdram_read_ack && word_match && !req_write) begin
            data_read <= word_byte(sdram_data_read, req_addr[0]);
        end
    end

    a_sdram_excl: assert property (@(posedge sys_clk) disable iff (!reset_n)
        !(sdram_read_req && sdram_write_req));

    a_ack_excl: assert property (@(posedge sys_clk) disable iff (!reset_n)
        !(read_ack && write_ack));

endmodule

// ==== cache_top.sv ====
module cache_top import cache_pkg::*; #(
    parameter bit READ_FORWARD = 1'b1
) (
    input  logic        sys_clk,
    input  logic        reset_n,
    input  host_addr_t  address,
    input  byte_t       data_write,
    input  logic        read_req,
    input  logic        write_req,
    output logic        read_ack,
    output byte_t       data_read,
    output logic        write_ack,
    output sdram_addr_t sdram_address,
    output word_t       sdram_data_write,
    input  word_t       sdram_data_read,
    output logic        sdram_read_req,
    output logic        sdram_write_req,
    input  logic        sdram_read_ack,
    input  logic        sdram_write_ack
);

    set_t       set_sel;
    tag_t       lookup_tag;
    logic       way_sel;
    logic       set_valid;
    logic       set_dirty;
    logic       touch;
    logic       hit_w0;
    logic       hit_w1;
    logic       victim_way;
    logic       victim_dirty;
    tag_t       victim_tag;
    ram_addr_t  ram_addr;
    word_t      ram_wdata;
    logic [1:0] ram_we_w0;
    logic [1:0] ram_we_w1;
    word_t      q_w0;
    word_t      q_w1;

    cache_ctrl #(
        .READ_FORWARD(READ_FORWARD)
    ) ctrl_i (
        .*
    );

    cache_tags tags_i (
        .*
    );

    // both ways share the address and data, only the write enables differ.
    cache_spram way_0_ram (
        .sys_clk(sys_clk),
        .addr   (ram_addr),
        .wdata  (ram_wdata),
        .we     (ram_we_w0),
        .q      (q_w0)
    );

    cache_spram way_1_ram (
        .sys_clk(sys_clk),
        .addr   (ram_addr),
        .wdata  (ram_wdata),
        .we     (ram_we_w1),
        .q      (q_w1)
    );

endmodule

// ==== tb_sdram_model.sv ====
module tb_sdram_model import cache_pkg::*; #(
    parameter int SEED = 0
) (
    input  logic        sys_clk,
    input  logic        reset_n,
    input  sdram_addr_t sdram_address,
    input  word_t       sdram_data_write,
    input  logic        sdram_read_req,
    input  logic        sdram_write_req,
    output word_t       sdram_data_read,
    output logic        sdram_read_ack,
    output logic        sdram_write_ack,
    // the transfer log pulses once per line and once per written-back word.
    output logic        xfer_start,
    output logic        xfer_write,
    output sdram_addr_t xfer_addr,
    output logic        wb_valid,
    output sdram_addr_t wb_addr,
    output word_t       wb_data
);
    timeunit 1ns;
    timeprecision 100ps;

    word_t  mem [1 << 16];
    integer seed;
    int     rd_sent;
    int     wr_sent;
    int     wr_taken;
    int     gap;

    initial begin
        seed = SEED;
        for (int i = 0; i < (1 << 16); i++) begin
            mem[i] = word_t'(i * 3);
        end
        sdram_data_read = '0;
        sdram_read_ack  = 1'b0;
        sdram_write_ack = 1'b0;
        xfer_start      = 1'b0;
        xfer_write      = 1'b0;
        xfer_addr       = '0;
        wb_valid        = 1'b0;
        wb_addr         = '0;
        wb_data         = '0;
    end

    always @(posedge sys_clk or negedge reset_n) begin
        if (!reset_n) begin
            sdram_read_ack  <= 1'b0;
            sdram_write_ack <= 1'b0;
            xfer_start      <= 1'b0;
            wb_valid        <= 1'b0;
            rd_sent         <= 0;
            wr_sent         <= 0;
            wr_taken        <= 0;
            gap             <= 0;
        end else begin
            sdram_read_ack  <= 1'b0;
            sdram_write_ack <= 1'b0;
            xfer_start      <= 1'b0;
            wb_valid        <= 1'b0;
            // the cache hands over its current word with every write ack.
            if (sdram_write_ack) begin
                mem[sdram_addr_t'(sdram_address + wr_taken)] <= sdram_data_write;
                wb_valid <= 1'b1;
                wb_addr  <= sdram_addr_t'(sdram_address + wr_taken);
                wb_data  <= sdram_data_write;
                wr_taken <= wr_taken + 1;
            end
            if (!sdram_read_req) begin
                rd_sent <= 0;
            end
            if (!sdram_write_req) begin
                wr_sent  <= 0;
                wr_taken <= 0;
            end
            // 0 to 3 idle cycles between acks.
            if (gap > 0) begin
                gap <= gap - 1;
            end else if (sdram_read_req && rd_sent < LINE_WORDS) begin
                sdram_read_ack  <= 1'b1;
                sdram_data_read <= mem[sdram_addr_t'(sdram_address + rd_sent)];
                rd_sent         <= rd_sent + 1;
                gap             <= $random(seed) & 3;
                xfer_start      <= (rd_sent == 0);
                xfer_write      <= 1'b0;
                xfer_addr       <= sdram_address;
            end else if (sdram_write_req && wr_sent < LINE_WORDS) begin
                sdram_write_ack <= 1'b1;
                wr_sent         <= wr_sent + 1;
                gap             <= $random(seed) & 3;
                xfer_start      <= (wr_sent == 0);
                xfer_write      <= 1'b1;
                xfer_addr       <= sdram_address;
            end
        end
    end

endmodule

// ==== tb_cache.sv ====
module tb_cache import cache_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 10;
    localparam int HIT_CYCLE    = 3;
    localparam int NUM_RANDOM   = 400;
    // directed requests stay below this count.
    localparam int NUM_DIRECTED = 16;
    localparam int LIMIT_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * 200 + RESET_CYCLES;
    localparam int SEED         = 32'h187b_9fde;

    logic        sys_clk = 1'b0;
    logic        reset_n;
    host_addr_t  address;
    byte_t       data_write;
    byte_t       data_read;
    logic        read_req, write_req, read_ack, write_ack;
    sdram_addr_t sdram_address;
    word_t       sdram_data_write, sdram_data_read;
    logic        sdram_read_req, sdram_write_req, sdram_read_ack, sdram_write_ack;
    logic        xfer_start, xfer_write, wb_valid;
    sdram_addr_t xfer_addr, wb_addr;
    word_t       wb_data;

    integer      seed = SEED;
    int          errors = 0;
    int          issued = 0;
    // host view of memory and the expected tag state.
    byte_t       ref_mem [1 << 17];
    tag_t        ref_tag [2][16];
    logic        ref_valid [2][16];
    logic        ref_dirty [2][16];
    logic        ref_lru [16];
    byte_t       exp_read [$];
    sdram_addr_t exp_fill [$];
    sdram_addr_t exp_wb [$];

    cache_top #(.READ_FORWARD(1'b1)) cache_top_i (.*);

    tb_sdram_model #(.SEED(SEED)) sdram_i (.*);

    always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s expected %0h actual %0h at %0t", name, expected, actual, $time);
        end
    endtask

    function automatic byte_t model_access(input host_addr_t a, input logic wr, input byte_t d,
                                           output logic fill, output logic wb,
                                           output sdram_addr_t fill_base,
                                           output sdram_addr_t wb_base);
        set_t s;
        tag_t t;
        logic way;
        s         = a[7:4];
        t         = a[16:8];
        fill      = 1'b0;
        wb        = 1'b0;
        fill_base = {t, s, 3'b000};
        wb_base   = '0;
        if (ref_valid[0][s] && ref_tag[0][s] == t) begin
            way = 1'b0;
        end else if (ref_valid[1][s] && ref_tag[1][s] == t) begin
            way = 1'b1;
        end else begin
            if (!ref_valid[0][s]) begin
                way = 1'b0;
            end else if (!ref_valid[1][s]) begin
                way = 1'b1;
            end else if (ref_dirty[0][s] != ref_dirty[1][s]) begin
                // the clean way goes.
                way = ref_dirty[0][s] ? 1'b1 : 1'b0;
            end else begin
                way = ref_lru[s];
            end
            fill             = 1'b1;
            wb               = ref_valid[way][s] && ref_dirty[way][s];
            wb_base          = {ref_tag[way][s], s, 3'b000};
            ref_tag[way][s]   = t;
            ref_valid[way][s] = 1'b1;
            ref_dirty[way][s] = 1'b0;
        end
        ref_lru[s] = ~way;
        if (wr) begin
            ref_mem[a]        = d;
            ref_dirty[way][s] = 1'b1;
        end
        return ref_mem[a];
    endfunction

    // issue one request at the current edge and wait for its ack.
    task automatic do_access(input host_addr_t a, input logic wr, input byte_t d);
        logic        fill;
        logic        wb;
        sdram_addr_t fill_base;
        sdram_addr_t wb_base;
        byte_t       exp;
        logic        busy;
        int          cyc;
        exp = model_access(a, wr, d, fill, wb, fill_base, wb_base);
        if (fill) begin
            exp_fill.push_back(fill_base);
        end
        if (wb) begin
            exp_wb.push_back(wb_base);
        end
        if (!wr) begin
            exp_read.push_back(exp);
        end
        // a request during a running fill waits in the pending slot.
        busy = sdram_read_req;
        issued++;
        address    <= a;
        data_write <= d;
        read_req   <= !wr;
        write_req  <= wr;
        @(posedge sys_clk);
        read_req  <= 1'b0;
        write_req <= 1'b0;
        cyc = 1;
        while (!(read_ack || write_ack)) begin
            @(posedge sys_clk);
            cyc++;
        end
        if (wr) begin
            check_value("write_ack", 1, write_ack);
        end else begin
            check_value("read_ack", 1, read_ack);
        end
        // the ack was high in the cycle that ended at this edge.
        if (!fill && !busy) begin
            check_value("hit ack cycle", HIT_CYCLE, cyc - 1);
        end
    endtask

    always @(posedge sys_clk) begin
        if (read_ack) begin
            if (exp_read.size() == 0) begin
                errors++;
                $display("read_ack came with no read outstanding at %0t", $time);
            end else begin
                check_value("data_read", exp_read.pop_front(), data_read);
            end
        end
        if (xfer_start && xfer_write) begin
            if (exp_wb.size() == 0) begin
                errors++;
                $display("unexpected write-back of line %0h at %0t", xfer_addr, $time);
            end else begin
                check_value("sdram_address", exp_wb.pop_front(), xfer_addr);
            end
        end
        if (xfer_start && !xfer_write) begin
            if (exp_fill.size() == 0) begin
                errors++;
                $display("unexpected fill of line %0h at %0t", xfer_addr, $time);
            end else begin
                check_value("sdram_address", exp_fill.pop_front(), xfer_addr);
            end
        end
        if (wb_valid) begin
            check_value("sdram_data_write", {ref_mem[{wb_addr, 1'b0}], ref_mem[{wb_addr, 1'b1}]},
                        wb_data);
        end
    end

    initial begin
        word_t      w;
        host_addr_t a;
        reset_n    = 1'b0;
        address    = '0;
        data_write = '0;
        read_req   = 1'b0;
        write_req  = 1'b0;
        for (int i = 0; i < (1 << 17); i++) begin
            w          = word_t'((i >> 1) * 3);
            ref_mem[i] = i[0] ? w[7:0] : w[15:8];
        end
        for (int s = 0; s < 16; s++) begin
            ref_lru[s] = 1'b0;
            for (int k = 0; k < 2; k++) begin
                ref_tag[k][s]   = '0;
                ref_valid[k][s] = 1'b0;
                ref_dirty[k][s] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(posedge sys_clk);
        reset_n <= 1'b1;
        @(posedge sys_clk);
        // cold miss, then a hit in the same line.
        do_access(17'h01234, 1'b0, 8'h00);
        do_access(17'h01239, 1'b0, 8'h00);
        // byte write next to an untouched byte.
        do_access(17'h0123e, 1'b1, 8'ha5);
        do_access(17'h0123e, 1'b0, 8'h00);
        do_access(17'h0123f, 1'b0, 8'h00);
        // three tags fight over set 5.
        do_access(17'h02154, 1'b1, 8'h11);
        do_access(17'h04254, 1'b1, 8'h22);
        do_access(17'h06354, 1'b0, 8'h00);
        do_access(17'h02155, 1'b0, 8'h00);
        do_access(17'h06354, 1'b1, 8'h33);
        do_access(17'h04254, 1'b0, 8'h00);
        do_access(17'h02154, 1'b0, 8'h00);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = host_addr_t'($random(seed)) & 17'h007ff;
            do_access(a, 1'($random(seed)), byte_t'($random(seed)));
        end
        repeat (40) @(posedge sys_clk);
        if (exp_read.size() != 0 || exp_fill.size() != 0 || exp_wb.size() != 0) begin
            errors++;
            $display("some expected reads or SDRAM transfers never happened");
        end
        $display("%0d requests, %0d errors", issued, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        errors++;
        $display("the cache stopped responding, %0d requests issued", issued);
        $display("%0d requests, %0d errors", issued, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== cache_top.f ====
cache_pkg.sv
cache_spram.sv
cache_tags.sv
cache_ctrl.sv
cache_top.sv
tb_sdram_model.sv
tb_cache.sv
